// File: source/issue_pkg.sv
package issue_pkg;

    // physical register tag and data widths
    localparam int tag_w = 5;
    localparam int xlen = 32;
    // one register per tag value
    localparam int phys_regs = 1 << tag_w;
    // one cdb lane per alu lane
    localparam int cdb_lanes = 2;
    // second operand field, wide enough for the immediate
    localparam int operand2_w = 16;

    // functional unit class
    typedef enum logic {
        ALU_T = 1'b0,
        MUL_T = 1'b1
    } unit_type_e;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

    // register view of the second operand, tag in the low bits
    typedef struct packed {
        logic [operand2_w-tag_w-1:0] pad;
        logic [tag_w-1:0]            tag;
    } operand2_tag_t;

    // use_imm picks which view is live
    typedef union packed {
        operand2_tag_t                tag_view;
        logic signed [operand2_w-1:0] imm;
    } operand2_u;

    typedef struct packed {
        unit_type_e       unit;
        logic [3:0]       rmask;
        logic [3:0]       wmask;
        alu_op_e          op;
        logic             use_imm;
        logic [tag_w-1:0] src1;
        operand2_u        src2;
        logic [tag_w-1:0] dest;
    } uop_t;

    // met bits come from the dispatcher
    typedef struct packed {
        uop_t uop;
        logic src1_met;
        logic src2_met;
    } dispatch_t;

    // table slot, only used inside the reservation table
    typedef struct packed {
        logic      full;
        dispatch_t disp;
    } rs_entry_t;

    typedef struct packed {
        logic valid;
        uop_t uop;
    } issue_t;

    typedef struct packed {
        logic [tag_w-1:0] rs1;
        logic [tag_w-1:0] rs2;
    } reg_request_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  value;
    } cdb_t;

endpackage

// File: source/reservation_table.sv
module reservation_table #(
    parameter int                    ss         = 2,
    parameter int                    table_size = 8,
    parameter issue_pkg::unit_type_e table_type = issue_pkg::ALU_T,
    parameter int                    request    = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  issue_pkg::dispatch_t   dispatched [ss],
    input  logic                   avail_inst,
    input  issue_pkg::cdb_t        cdb [request],
    input  logic                   fu_ready [request],
    output issue_pkg::issue_t      issue [request],
    output issue_pkg::reg_request_t reg_request [request],
    output logic                   table_full
);
    import issue_pkg::*;

    // stored entries and their next state
    rs_entry_t    table_q [table_size];
    rs_entry_t    table_d [table_size];
    // per entry: both operands met
    logic [table_size-1:0] ready;
    // entries claimed by a lane this cycle
    logic [table_size-1:0] picked;
    // free entries claimed by a dispatch slot this cycle
    logic [table_size-1:0] taken;
    // slot passes the type and mask filter
    logic [ss-1:0]         accept;
    logic                  lane_found;
    logic                  slot_placed;
    dispatch_t             incoming;
    issue_t                issue_d [request];
    reg_request_t          request_d [request];

    // tag compare against one cdb lane
    function automatic dispatch_t wake(input dispatch_t d, input cdb_t c);
        dispatch_t w;
        w = d;
        if (c.valid && (d.uop.src1 == c.tag)) begin
            w.src1_met = 1'b1;
        end
        // immediate view holds no tag
        if (c.valid && !d.uop.use_imm && (d.uop.src2.tag_view.tag == c.tag)) begin
            w.src2_met = 1'b1;
        end
        return w;
    endfunction

    always_comb begin
        for (int j = 0; j < table_size; j++) begin
            ready[j] = table_q[j].full && table_q[j].disp.src1_met
                       && (table_q[j].disp.src2_met || table_q[j].disp.uop.use_imm);
        end
    end

    // lane 0 picks first, higher lanes skip what lower lanes took
    always_comb begin
        picked = '0;
        for (int i = 0; i < request; i++) begin
            issue_d[i] = '0;
            request_d[i] = '0;
            lane_found = 1'b0;
            for (int j = 0; j < table_size; j++) begin
                if (fu_ready[i] && !lane_found && ready[j] && !picked[j]) begin
                    lane_found = 1'b1;
                    picked[j] = 1'b1;
                    issue_d[i].valid = 1'b1;
                    issue_d[i].uop = table_q[j].disp.uop;
                    request_d[i].rs1 = table_q[j].disp.uop.src1;
                    // no register read behind an immediate
                    if (!table_q[j].disp.uop.use_imm) begin
                        request_d[i].rs2 = table_q[j].disp.uop.src2.tag_view.tag;
                    end
                end
            end
        end
    end

    // only alu-class ops without memory access belong here
    always_comb begin
        for (int s = 0; s < ss; s++) begin
            accept[s] = avail_inst && !table_full
                        && (dispatched[s].uop.unit == table_type)
                        && (dispatched[s].uop.rmask == 4'b0)
                        && (dispatched[s].uop.wmask == 4'b0);
        end
    end

    always_comb begin
        taken = '0;
        // wakeup on resident entries, then free the issued ones
        for (int j = 0; j < table_size; j++) begin
            table_d[j] = table_q[j];
            for (int i = 0; i < request; i++) begin
                table_d[j].disp = wake(table_d[j].disp, cdb[i]);
            end
            if (picked[j]) begin
                table_d[j].full = 1'b0;
            end
        end
        // insert each slot into the lowest free entry
        for (int s = 0; s < ss; s++) begin
            incoming = dispatched[s];
            // a broadcast in the dispatch cycle must not be missed
            for (int i = 0; i < request; i++) begin
                incoming = wake(incoming, cdb[i]);
            end
            slot_placed = 1'b0;
            for (int j = 0; j < table_size; j++) begin
                if (accept[s] && !slot_placed && !table_q[j].full && !taken[j]) begin
                    slot_placed = 1'b1;
                    taken[j] = 1'b1;
                    table_d[j].full = 1'b1;
                    table_d[j].disp = incoming;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int j = 0; j < table_size; j++) begin
                table_q[j].full <= 1'b0;
            end
            for (int i = 0; i < request; i++) begin
                issue[i] <= '0;
                reg_request[i] <= '0;
            end
        end else begin
            for (int j = 0; j < table_size; j++) begin
                table_q[j] <= table_d[j];
            end
            for (int i = 0; i < request; i++) begin
                issue[i] <= issue_d[i];
                reg_request[i] <= request_d[i];
            end
        end
    end

    // full only when every entry is occupied
    always_comb begin
        table_full = 1'b1;
        for (int j = 0; j < table_size; j++) begin
            table_full = table_full & table_q[j].full;
        end
    end

endmodule

// File: source/phys_reg_file.sv
module phys_reg_file #(
    parameter int request = 2
) (
    input  logic                          clk,
    input  logic                          rst,
    input  issue_pkg::reg_request_t       reg_request [request],
    input  issue_pkg::cdb_t               cdb [request],
    output logic [issue_pkg::xlen-1:0]    rs1_value [request],
    output logic [issue_pkg::xlen-1:0]    rs2_value [request]
);
    import issue_pkg::*;

    logic [xlen-1:0] regs [phys_regs];

    // array read with bypass from a same-cycle cdb write
    function automatic logic [xlen-1:0] read_port(input logic [tag_w-1:0] tag);
        logic [xlen-1:0] data;
        data = regs[tag];
        for (int k = 0; k < request; k++) begin
            if (cdb[k].valid && (cdb[k].tag == tag)) begin
                data = cdb[k].value;
            end
        end
        // tag zero is hardwired
        if (tag == '0) begin
            data = '0;
        end
        return data;
    endfunction

    // two read ports per lane
    always_comb begin
        for (int i = 0; i < request; i++) begin
            rs1_value[i] = read_port(reg_request[i].rs1);
            rs2_value[i] = read_port(reg_request[i].rs2);
        end
    end

    // one write per cdb lane, tag zero never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < phys_regs; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int k = 0; k < request; k++) begin
                if (cdb[k].valid && (cdb[k].tag != '0)) begin
                    regs[cdb[k].tag] <= cdb[k].value;
                end
            end
        end
    end

endmodule

// File: source/alu_lane.sv
module alu_lane (
    input  logic                       clk,
    input  logic                       rst,
    input  issue_pkg::issue_t          issue,
    input  logic [issue_pkg::xlen-1:0] rs1_value,
    input  logic [issue_pkg::xlen-1:0] rs2_value,
    output issue_pkg::cdb_t            cdb
);
    import issue_pkg::*;

    // shift amount uses the low bits only
    localparam int shamt_w = $clog2(xlen);

    logic [xlen-1:0] op_b;
    logic [xlen-1:0] result;
    logic            less;

    // second operand, immediate view is sign extended
    always_comb begin
        if (issue.uop.use_imm) begin
            op_b = {{(xlen-operand2_w){issue.uop.src2.imm[operand2_w-1]}},
                    issue.uop.src2.imm};
        end else begin
            op_b = rs2_value;
        end
    end

    // signed compare for slt
    assign less = $signed(rs1_value) < $signed(op_b);

    always_comb begin
        case (issue.uop.op)
            ADD:     result = rs1_value + op_b;
            SUB:     result = rs1_value - op_b;
            AND:     result = rs1_value & op_b;
            OR:      result = rs1_value | op_b;
            XOR:     result = rs1_value ^ op_b;
            SLL:     result = rs1_value << op_b[shamt_w-1:0];
            // logical right shift
            SRL:     result = rs1_value >> op_b[shamt_w-1:0];
            SLT:     result = {{(xlen-1){1'b0}}, less};
            default: result = '0;
        endcase
    end

    // result onto this lane's cdb one edge after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue.valid;
        end
        cdb.tag <= issue.uop.dest;
        cdb.value <= result;
    end

endmodule

// File: source/issue_core.sv
module issue_core #(
    parameter int                    ss         = 2,
    parameter int                    table_size = 8,
    parameter issue_pkg::unit_type_e table_type = issue_pkg::ALU_T,
    parameter int                    request    = issue_pkg::cdb_lanes
) (
    input  logic                 clk,
    input  logic                 rst,
    input  issue_pkg::dispatch_t dispatched [ss],
    input  logic                 avail_inst,
    input  logic                 fu_ready [request],
    output issue_pkg::cdb_t      cdb [request],
    output logic                 table_full
);
    import issue_pkg::*;

    // table to lanes and register file
    issue_t          issue [request];
    reg_request_t    reg_request [request];
    // register file to lanes
    logic [xlen-1:0] rs1_value [request];
    logic [xlen-1:0] rs2_value [request];

    reservation_table #(
        .ss         (ss),
        .table_size (table_size),
        .table_type (table_type),
        .request    (request)
    ) u_table (
        .clk         (clk),
        .rst         (rst),
        .dispatched  (dispatched),
        .avail_inst  (avail_inst),
        .cdb         (cdb),
        .fu_ready    (fu_ready),
        .issue       (issue),
        .reg_request (reg_request),
        .table_full  (table_full)
    );

    // cdb also feeds the write ports
    phys_reg_file #(
        .request (request)
    ) u_prf (
        .clk         (clk),
        .rst         (rst),
        .reg_request (reg_request),
        .cdb         (cdb),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value)
    );

    // one alu per issue lane, each owns a cdb lane
    for (genvar i = 0; i < request; i++) begin : g_alu
        alu_lane u_alu (
            .clk       (clk),
            .rst       (rst),
            .issue     (issue[i]),
            .rs1_value (rs1_value[i]),
            .rs2_value (rs2_value[i]),
            .cdb       (cdb[i])
        );
    end

endmodule

// File: sim/issue_core_properties.sv
module issue_core_properties #(
    parameter int table_size = 8,
    parameter int request    = 2
) (
    input logic                 clk,
    input logic                 rst,
    input issue_pkg::rs_entry_t entries [table_size],
    input logic                 fu_ready [request],
    input issue_pkg::issue_t    issue [request],
    input logic                 table_full
);
    // occupancy of every entry
    logic [table_size-1:0] full_bits;

    always_comb begin
        for (int j = 0; j < table_size; j++) begin
            full_bits[j] = entries[j].full;
        end
    end

    // a group offered while full must not land in any entry
    a_no_insert_when_full: assert property (@(posedge clk) disable iff (rst)
        table_full |=> ((full_bits & ~$past(full_bits)) == '0))
    else $error("entry filled while table_full was high");

    // two lanes never get the same micro-op
    a_distinct_dest: assert property (@(posedge clk) disable iff (rst)
        (issue[0].valid && issue[1].valid) |-> (issue[0].uop.dest != issue[1].uop.dest))
    else $error("both issue lanes carry the same dest tag");

    for (genvar i = 0; i < request; i++) begin : g_lane
        a_no_issue_when_held: assert property (@(posedge clk) disable iff (rst)
            !fu_ready[i] |=> !issue[i].valid)
        else $error("issue on lane %0d after fu_ready was low", i);
    end

endmodule

bind reservation_table issue_core_properties #(
    .table_size (table_size),
    .request    (request)
) u_props (
    .clk        (clk),
    .rst        (rst),
    .entries    (table_q),
    .fu_ready   (fu_ready),
    .issue      (issue),
    .table_full (table_full)
);

// File: sim/issue_core_tb.sv
module issue_core_tb;
    import issue_pkg::*;

    // several times the summed length of the tests
    localparam int cycle_limit = 600;

    logic      clk = 1'b0;
    logic      rst;
    dispatch_t dispatched [2];
    logic      avail_inst;
    logic      fu_ready [2];
    cdb_t      cdb [2];
    logic      table_full;

    int seed;
    int cycles;
    int errors;
    int checks;
    int sent_cycle;
    // expected register contents in program order
    logic [xlen-1:0] model [32];
    // cdb pulses seen per tag
    int              seen_count [32];
    logic [xlen-1:0] seen_value [32];
    int              seen_lane [32];
    int              seen_cycle [32];

    issue_core #(
        .ss         (2),
        .table_size (8),
        .table_type (ALU_T),
        .request    (2)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .dispatched (dispatched),
        .avail_inst (avail_inst),
        .fu_ready   (fu_ready),
        .cdb        (cdb),
        .table_full (table_full)
    );

    always #4 clk = ~clk;

    // cycle count and run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: no finish after %0d cycles, checks: %0d, errors: %0d",
                     cycles, checks, errors);
            $display("** FAIL **");
            $finish;
        end
    end

    // registered cdb is stable at the falling edge
    always @(negedge clk) begin
        collect_cdb();
    end

    task automatic collect_cdb();
        for (int i = 0; i < 2; i++) begin
            if (cdb[i].valid) begin
                seen_count[cdb[i].tag]++;
                seen_value[cdb[i].tag] = cdb[i].value;
                seen_lane[cdb[i].tag] = i;
                seen_cycle[cdb[i].tag] = cycles;
            end
        end
    endtask

    task automatic clear_seen();
        for (int t = 0; t < 32; t++) begin
            seen_count[t] = 0;
            seen_value[t] = '0;
            seen_lane[t] = -1;
            seen_cycle[t] = 0;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [xlen-1:0] exp,
                                   input logic [xlen-1:0] act);
        errors++;
        $display("Fail %s expected %h actual %h", name, exp, act);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    // reference alu result per opcode
    function automatic logic [xlen-1:0] alu_ref(input alu_op_e op, input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic dispatch_t make_op(input alu_op_e op, input logic [4:0] src1,
                                          input logic met1, input logic use_imm,
                                          input logic [15:0] src2, input logic met2,
                                          input logic [4:0] dest);
        dispatch_t d;
        d = '0;
        d.uop.unit = ALU_T;
        d.uop.op = op;
        d.uop.use_imm = use_imm;
        d.uop.src1 = src1;
        // caller zero pads a tag into the raw field
        d.uop.src2.imm = src2;
        d.uop.dest = dest;
        d.src1_met = met1;
        d.src2_met = met2;
        return d;
    endfunction

    // unused slot dropped by the type filter
    function automatic dispatch_t idle_slot();
        dispatch_t d;
        d = '0;
        d.uop.unit = MUL_T;
        return d;
    endfunction

    function automatic logic [15:0] random_imm();
        int rnd;
        rnd = $random(seed);
        return rnd[15:0];
    endfunction

    task automatic record_expected(input dispatch_t d);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        a = model[d.uop.src1];
        if (d.uop.use_imm) begin
            b = {{16{d.uop.src2.imm[15]}}, d.uop.src2.imm};
        end else begin
            b = model[d.uop.src2.tag_view.tag];
        end
        model[d.uop.dest] = alu_ref(d.uop.op, a, b);
    endtask

    // one group on the strobe for one cycle
    task automatic send(input dispatch_t d0, input dispatch_t d1);
        dispatched[0] = d0;
        dispatched[1] = d1;
        avail_inst = 1'b1;
        sent_cycle = cycles;
        @(posedge clk);
        #1;
        avail_inst = 1'b0;
        dispatched[0] = idle_slot();
        dispatched[1] = idle_slot();
    endtask

    task automatic check_result(input string name, input logic [4:0] tag);
        while (seen_count[tag] == 0) begin
            @(posedge clk);
            #1;
        end
        checks++;
        assert (seen_value[tag] == model[tag])
        else report_mismatch(name, model[tag], seen_value[tag]);
        assert (seen_count[tag] == 1)
        else report_problem($sformatf("%s: tag %0d broadcast more than once", name, tag));
    endtask

    task automatic test_imm_ops();
        dispatch_t d;
        clear_seen();
        for (int k = 1; k <= 4; k++) begin
            d = make_op(ADD, 5'd0, 1'b1, 1'b1, random_imm(), 1'b1, 5'(k));
            record_expected(d);
            send(d, idle_slot());
            check_result("imm_ops", 5'(k));
            // ready entry reaches the cdb after three edges
            assert (seen_cycle[k] - sent_cycle == 3)
            else report_problem($sformatf("imm_ops: tag %0d took %0d edges",
                                          k, seen_cycle[k] - sent_cycle));
        end
    endtask

    task automatic test_chain();
        dispatch_t  a;
        dispatch_t  b;
        dispatch_t  c;
        alu_op_e    op;
        logic [4:0] p1;
        logic [4:0] p2;
        logic [4:0] dst;
        clear_seen();
        for (int k = 0; k < 8; k++) begin
            op = alu_op_e'(k);
            p1 = 5'(5 + 3 * k);
            p2 = p1 + 5'd1;
            dst = p1 + 5'd2;
            a = make_op(ADD, 5'd0, 1'b1, 1'b1, random_imm(), 1'b1, p1);
            b = make_op(ADD, 5'd0, 1'b1, 1'b1, random_imm(), 1'b1, p2);
            // consumer waits on both producers
            c = make_op(op, p1, 1'b0, 1'b0, 16'(p2), 1'b0, dst);
            record_expected(a);
            record_expected(b);
            record_expected(c);
            // consumer goes in ahead of its producers
            send(c, idle_slot());
            send(a, b);
            check_result("chain", p1);
            check_result("chain", p2);
            check_result($sformatf("chain %s", op.name()), dst);
            assert (seen_cycle[dst] > seen_cycle[p1] && seen_cycle[dst] > seen_cycle[p2])
            else report_problem($sformatf("chain %s issued before its producers", op.name()));
        end
    endtask

    task automatic test_filter();
        dispatch_t m;
        dispatch_t w;
        dispatch_t v1;
        dispatch_t v2;
        clear_seen();
        m = make_op(ADD, 5'd0, 1'b1, 1'b1, random_imm(), 1'b1, 5'd29);
        m.uop.unit = MUL_T;
        w = make_op(ADD, 5'd0, 1'b1, 1'b1, random_imm(), 1'b1, 5'd31);
        w.uop.wmask = 4'b0010;
        v1 = make_op(ADD, 5'd0, 1'b1, 1'b1, random_imm(), 1'b1, 5'd30);
        v2 = make_op(XOR, 5'd30, 1'b0, 1'b1, random_imm(), 1'b1, 5'd1);
        record_expected(v1);
        record_expected(v2);
        send(m, v1);
        send(w, v2);
        check_result("filter", 5'd30);
        check_result("filter", 5'd1);
        repeat (3) @(posedge clk);
        #1;
        assert (seen_count[29] == 0 && seen_count[31] == 0)
        else report_problem("filter: a dropped micro-op reached the cdb");
    endtask

    task automatic test_full_table();
        dispatch_t p;
        dispatch_t w [7];
        dispatch_t x0;
        dispatch_t x1;
        clear_seen();
        // both lanes held so the producer stays resident
        fu_ready[0] = 1'b0;
        fu_ready[1] = 1'b0;
        p = make_op(ADD, 5'd0, 1'b1, 1'b1, random_imm(), 1'b1, 5'd2);
        record_expected(p);
        for (int k = 0; k < 7; k++) begin
            w[k] = make_op(ADD, 5'd2, 1'b0, 1'b1, random_imm(), 1'b1, 5'(3 + k));
            record_expected(w[k]);
        end
        send(p, w[0]);
        send(w[1], w[2]);
        send(w[3], w[4]);
        send(w[5], w[6]);
        assert (table_full)
        else report_problem("full_table: table_full low with eight entries held");
        // this group must be ignored
        x0 = make_op(ADD, 5'd0, 1'b1, 1'b1, random_imm(), 1'b1, 5'd11);
        x1 = make_op(ADD, 5'd0, 1'b1, 1'b1, random_imm(), 1'b1, 5'd12);
        send(x0, x1);
        assert (table_full)
        else report_problem("full_table: table_full dropped while lanes were held");
        fu_ready[0] = 1'b1;
        fu_ready[1] = 1'b1;
        for (int t = 2; t <= 9; t++) begin
            check_result("full_table", 5'(t));
        end
        repeat (3) @(posedge clk);
        #1;
        assert (!table_full)
        else report_problem("full_table: table_full still high after draining");
        assert (seen_count[11] == 0 && seen_count[12] == 0)
        else report_problem("full_table: group sent while full reached the cdb");
    endtask

    task automatic test_back_pressure();
        dispatch_t d [4];
        dispatch_t a;
        dispatch_t b;
        clear_seen();
        fu_ready[1] = 1'b0;
        // tag 1 is read from the register file
        for (int k = 0; k < 4; k++) begin
            d[k] = make_op(alu_op_e'(2 * k + 1), 5'd1, 1'b1, 1'b1, random_imm(), 1'b1,
                           5'(13 + k));
            record_expected(d[k]);
        end
        send(d[0], d[1]);
        send(d[2], d[3]);
        for (int t = 13; t <= 16; t++) begin
            check_result("back_pressure", 5'(t));
            assert (seen_lane[t] == 0)
            else report_problem($sformatf("back_pressure: tag %0d came out on held lane", t));
        end
        fu_ready[1] = 1'b1;
        a = make_op(SUB, 5'd13, 1'b1, 1'b0, 16'(5'd14), 1'b1, 5'd17);
        b = make_op(OR, 5'd15, 1'b1, 1'b0, 16'(5'd16), 1'b1, 5'd18);
        record_expected(a);
        record_expected(b);
        send(a, b);
        check_result("back_pressure", 5'd17);
        check_result("back_pressure", 5'd18);
        assert (seen_cycle[17] == seen_cycle[18] && seen_lane[17] != seen_lane[18])
        else report_problem("back_pressure: ready pair did not complete on both lanes at once");
    endtask

    initial begin
        seed = 13131;
        cycles = 0;
        errors = 0;
        checks = 0;
        sent_cycle = 0;
        rst = 1'b1;
        avail_inst = 1'b0;
        dispatched[0] = idle_slot();
        dispatched[1] = idle_slot();
        fu_ready[0] = 1'b1;
        fu_ready[1] = 1'b1;
        for (int t = 0; t < 32; t++) begin
            model[t] = '0;
        end
        clear_seen();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        test_imm_ops();
        test_chain();
        test_filter();
        test_full_table();
        test_back_pressure();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: project.f
source/issue_pkg.sv
source/reservation_table.sv
source/phys_reg_file.sv
source/alu_lane.sv
source/issue_core.sv
sim/issue_core_properties.sv
sim/issue_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the issue stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --assert --top-module issue_core_tb \
        -f project.f -o issue_core_sim; then
    echo "compile failed"
    exit 1
fi

./obj_dir/issue_core_sim > "$log" 2>&1
status=$?
cat "$log"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '** FAIL **' "$log"; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0
